// File: Makefile
TOP = SmAluTb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --top-module $(TOP) -f sim.f -o $(TOP)

run: compile
	-./obj_dir/$(TOP) > sim.log 2>&1
	@cat sim.log
	@if grep -q "TESTS FAILED" sim.log; then \
		echo "simulation failed"; \
		exit 1; \
	elif ! grep -q "TESTS PASSED" sim.log; then \
		echo "simulation ended without a verdict"; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log

// File: bench/SmAluTb.sv
// SmAluTb runs directed and random items through the sign-magnitude ALU and checks each result.
`timescale 1ns/1ps
`include "smAlu_params.svh"

module SmAluTb;

    import smAluPkg::*;

    localparam int numDirected = 18;
    localparam int numRandom   = 200;
    localparam int resetCycles = 4;
    localparam int cycleLimit  = 2 * (numDirected + numRandom + `SMALU_LATENCY + resetCycles);
    localparam int magW        = `SMALU_WIDTH - 1;
    localparam logic [15:0] lfsrSeed = 16'd37007;

    typedef struct packed {
        aluOp_e  op;
        smWord_t op1;
        smWord_t op2;
        logic    carryIn;
        smWord_t expDiff;
        logic    expOvf;
    } vector_t;

    logic        clk;
    logic        rstN;
    logic        inValid;
    aluOp_e      op;
    smWord_t     op1;
    smWord_t     op2;
    logic        carryIn;
    logic        outValid;
    smWord_t     diff;
    logic        ovf;
    logic [15:0] lfsrState;
    int          cycles = 0;
    smWord_t     expDiffQ [$];
    logic        expOvfQ  [$];
    int          issueQ   [$];  // cycle count at which each item went in.

    // op, op1, op2, carryIn, expected diff, expected ovf.
    vector_t directed [numDirected] = '{
        '{OP_ADD,  32'h0000_0005, 32'h0000_0003, 1'b0, 32'h0000_0008, 1'b0},
        '{OP_ADD,  32'h0000_0005, 32'h8000_0008, 1'b0, 32'h8000_0003, 1'b0},
        '{OP_ADDC, 32'h0000_000A, 32'h0000_0014, 1'b1, 32'h0000_001F, 1'b0},
        '{OP_ADDC, 32'h8000_0007, 32'h0000_0002, 1'b0, 32'h8000_0005, 1'b0},
        '{OP_SUB,  32'h0000_0064, 32'h0000_001E, 1'b0, 32'h0000_0046, 1'b0},
        '{OP_SUBB, 32'h0000_0064, 32'h0000_001E, 1'b1, 32'h0000_0045, 1'b0},
        '{OP_SUBB, 32'h8000_0005, 32'h8000_0009, 1'b1, 32'h0000_0003, 1'b0},
        '{OP_SUBB, 32'h8000_0009, 32'h8000_0005, 1'b1, 32'h8000_0005, 1'b0},
        '{OP_SUBB, 32'h0000_0004, 32'h8000_0006, 1'b0, 32'h0000_000A, 1'b0},
        '{OP_SUBB, 32'h8000_0004, 32'h0000_0006, 1'b1, 32'h8000_000B, 1'b0},
        '{OP_ADD,  32'h8000_0000, 32'h8000_0000, 1'b0, 32'h0000_0000, 1'b0},
        '{OP_SUB,  32'h0000_0007, 32'h0000_0007, 1'b0, 32'h0000_0000, 1'b0},
        '{OP_SUBB, 32'h0000_0001, 32'h8000_0000, 1'b1, 32'h0000_0000, 1'b0},
        '{OP_ADD,  32'h8000_0006, 32'h0000_0006, 1'b0, 32'h0000_0000, 1'b0},
        '{OP_ADD,  32'h7FFF_FFFF, 32'h0000_0001, 1'b0, 32'h7FFF_FFFF, 1'b1},
        '{OP_SUB,  32'hFFFF_FFFF, 32'h0000_0001, 1'b0, 32'hFFFF_FFFF, 1'b1},
        '{OP_SUBB, 32'hFFFF_FFFE, 32'h0000_0000, 1'b1, 32'hFFFF_FFFF, 1'b0},
        '{OP_ADDC, 32'h7FFF_FFFF, 32'h7FFF_FFFF, 1'b1, 32'h7FFF_FFFF, 1'b1}
    };

    SmAluTop dut_i (
        .clk     (clk),
        .rstN    (rstN),
        .inValid (inValid),
        .op      (op),
        .op1     (op1),
        .op2     (op2),
        .carryIn (carryIn),
        .outValid(outValid),
        .diff    (diff),
        .ovf     (ovf)
    );

    // ####################
    // helpers
    // ####################

    task automatic abortRun(input string why);
        $display("%s", why);
        $display("TESTS FAILED");
        $fatal(1);
    endtask

    task automatic checkWord(input string name, input smWord_t got, input smWord_t exp);
        if (got !== exp) begin
            abortRun($sformatf("mismatch at %0d ns: %s got %h expected %h", $time, name, got, exp));
        end
    endtask

    task automatic checkFlag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            abortRun($sformatf("mismatch at %0d ns: %s got %b expected %b", $time, name, got, exp));
        end
    endtask

    task automatic checkCount(input string name, input int got, input int exp);
        if (got != exp) begin
            abortRun($sformatf("mismatch at %0d ns: %s got %0d expected %0d", $time, name, got, exp));
        end
    endtask

    // taps for x^16 + x^14 + x^13 + x^11 + 1.
    function automatic logic [15:0] lfsrNext(input logic [15:0] s);
        logic fb;
        fb = s[15] ^ s[13] ^ s[12] ^ s[10];
        return {s[14:0], fb};
    endfunction

    task automatic drawBits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsrState = lfsrNext(lfsrState);
            v = {v[30:0], lfsrState[0]}; // one step per bit taken.
        end
    endtask

    // exact signed arithmetic, then saturation to the largest magnitude.
    task automatic modelResult(input aluOp_e mOp, input smWord_t a, input smWord_t b,
                               input logic cin, output smWord_t res, output logic over);
        longint x;
        longint y;
        longint r;
        longint mag;
        longint maxMag;
        maxMag = (longint'(1) <<< magW) - 1;
        x = a[magW] ? -longint'(a[magW-1:0]) : longint'(a[magW-1:0]);
        y = b[magW] ? -longint'(b[magW-1:0]) : longint'(b[magW-1:0]);
        case (mOp)
            OP_ADD:  r = x + y;
            OP_SUB:  r = x - y;
            OP_ADDC: r = x + y + longint'(cin);
            default: r = x - y - longint'(cin);
        endcase
        over = (r > maxMag) || (r < -maxMag);
        if (r > maxMag) begin
            mag = maxMag;
        end else if (r < -maxMag) begin
            mag = maxMag;
        end else begin
            mag = (r < 0) ? -r : r;
        end
        res = {r < 0, mag[magW-1:0]}; // a zero result never has r below zero.
    endtask

    task automatic issueItem(input aluOp_e iOp, input smWord_t a, input smWord_t b,
                             input logic cin, input smWord_t eDiff, input logic eOvf);
        @(negedge clk);
        inValid = 1'b1;
        op      = iOp;
        op1     = a;
        op2     = b;
        carryIn = cin;
        expDiffQ.push_back(eDiff);
        expOvfQ.push_back(eOvf);
        issueQ.push_back(cycles);
    endtask

    // ####################
    // clock and timeout
    // ####################

    // the clock starts high, so the first falling edge opens the reset.
    initial begin
        clk = 1'b1;
        forever begin
            #50 clk = ~clk;
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= cycleLimit) begin
            abortRun($sformatf("timeout after %0d cycles with %0d results still missing",
                               cycles, expDiffQ.size()));
        end
    end

    // ####################
    // result checking
    // ####################

    // outputs are registered, so the falling edge sees them settled.
    always @(negedge clk) begin
        if (outValid === 1'b1) begin
            if (expDiffQ.size() == 0) begin
                abortRun($sformatf("outValid went high at %0d ns with no item in flight", $time));
            end else begin
                checkCount("latency", cycles - issueQ.pop_front(), `SMALU_LATENCY);
                checkWord("diff", diff, expDiffQ.pop_front());
                checkFlag("ovf", ovf, expOvfQ.pop_front());
            end
        end
    end

    // ####################
    // stimulus
    // ####################

    initial begin
        logic [31:0] bits;
        aluOp_e      rOp;
        smWord_t     rA;
        smWord_t     rB;
        logic        rCin;
        smWord_t     eDiff;
        logic        eOvf;
        rstN      = 1'b1;
        inValid   = 1'b0;
        op        = OP_ADD;
        op1       = '0;
        op2       = '0;
        carryIn   = 1'b0;
        lfsrState = lfsrSeed;

        @(negedge clk);
        rstN = 1'b0;
        repeat (resetCycles) @(negedge clk);
        rstN = 1'b1;

        for (int i = 0; i < numDirected; i++) begin
            issueItem(directed[i].op, directed[i].op1, directed[i].op2, directed[i].carryIn,
                      directed[i].expDiff, directed[i].expOvf);
        end

        for (int i = 0; i < numRandom; i++) begin
            drawBits(2, bits);
            rOp = aluOp_e'(bits[1:0]);
            drawBits(32, bits);
            rA = bits;
            drawBits(32, bits);
            rB = bits;
            drawBits(1, bits);
            rCin = bits[0];
            modelResult(rOp, rA, rB, rCin, eDiff, eOvf);
            issueItem(rOp, rA, rB, rCin, eDiff, eOvf);
        end

        @(negedge clk);
        inValid = 1'b0;

        while (expDiffQ.size() != 0) begin
            @(negedge clk);
        end
        repeat (2 * `SMALU_LATENCY) @(negedge clk); // nothing more may come out.
        $display("TESTS PASSED");
        $finish;
    end

endmodule

// File: bench/smAlu_asserts.sv
// SmAluAsserts watches valid timing, reset behavior and the zero sign at the ALU outputs.
`timescale 1ns/1ps
`include "smAlu_params.svh"

module SmAluAsserts (
    input logic              clk,
    input logic              rstN,
    input logic              inValid,
    input logic              outValid,
    input smAluPkg::smWord_t diff
);

    // ####################
    // pipeline timing
    // ####################

    latencyHolds: assert property (@(posedge clk) disable iff (!rstN)
        outValid == $past(inValid, `SMALU_LATENCY))
        else $error("outValid did not follow inValid by the pipeline latency");

    resetClears: assert property (@(posedge clk) !rstN |-> !outValid)
        else $error("outValid was high during reset");

    // a zero result always leaves with the plus sign.
    noNegZero: assert property (@(posedge clk) disable iff (!rstN)
        outValid |-> !(diff[`SMALU_WIDTH-1] && (diff[`SMALU_WIDTH-2:0] == '0)))
        else $error("diff showed a negative zero");

endmodule

bind SmAluTop SmAluAsserts asserts_i (
    .clk     (clk),
    .rstN    (rstN),
    .inValid (inValid),
    .outValid(outValid),
    .diff    (diff)
);

// File: common/smAluPkg.sv
// smAlu package with the opcode set and the word types shared by the pipeline.
`include "smAlu_params.svh"

package smAluPkg;

    // ####################
    // opcodes
    // ####################

    // the borrow-in form subtracts carryIn on top of op2.
    typedef enum logic [1:0] {
        OP_ADD  = 2'b00,
        OP_SUB  = 2'b01,
        OP_ADDC = 2'b10,
        OP_SUBB = 2'b11
    } aluOp_e;

    // ####################
    // word types
    // ####################

    // bit 31 is the sign, bits 30:0 hold the magnitude.
    typedef logic [`SMALU_WIDTH-1:0] smWord_t;

    // one guard bit above the word keeps the sum of two operands from wrapping.
    typedef logic [`SMALU_WIDTH:0] twosWord_t;

endpackage

// File: common/smAlu_params.svh
// smAlu parameters for word width, lookahead group width and pipeline depth.
`ifndef SMALU_PARAMS_SVH
`define SMALU_PARAMS_SVH

// width of a sign-magnitude word, sign included.
`define SMALU_WIDTH 32

// bits per generate/propagate group in the lookahead adder.
`define SMALU_GROUP 4

// cycles from an accepted input to its result.
`define SMALU_LATENCY 3

`endif

// File: convert/SignMagToTwos.sv
// SignMagToTwos turns a sign-magnitude word into a 33-bit two's-complement value.
`timescale 1ns/1ps
`include "smAlu_params.svh"

module SignMagToTwos (
    input  smAluPkg::smWord_t   sm,
    output smAluPkg::twosWord_t twos
);

    import smAluPkg::*;

    localparam int magW = `SMALU_WIDTH - 1;

    twosWord_t magExt;
    twosWord_t negated;

    assign magExt = {2'b00, sm[magW-1:0]}; // magnitude with sign and guard cleared.

    // negation is the inverted magnitude plus one.
    LookaheadAdder #(
        .width(`SMALU_WIDTH + 1)
    ) negAdder (
        .a   (~magExt),
        .b   ('0),
        .cin (1'b1),
        .sum (negated),
        .cout()
    );

    // a zero magnitude is zero whatever the sign says.
    assign twos = (magExt == '0)   ? '0 :
                  sm[`SMALU_WIDTH-1] ? negated : magExt;

endmodule

// File: convert/TwosToSignMag.sv
// TwosToSignMag turns a 33-bit sum back into sign-magnitude, saturating on overflow.
`timescale 1ns/1ps
`include "smAlu_params.svh"

module TwosToSignMag (
    input  smAluPkg::twosWord_t twos,
    output smAluPkg::smWord_t   sm,
    output logic                ovf
);

    import smAluPkg::*;

    localparam int magW = `SMALU_WIDTH - 1;

    twosWord_t       negated;
    twosWord_t       absVal;
    logic [magW-1:0] magOut;

    LookaheadAdder #(
        .width(`SMALU_WIDTH + 1)
    ) absAdder (
        .a   (~twos),
        .b   ('0),
        .cin (1'b1),
        .sum (negated),
        .cout()
    );

    assign absVal = twos[`SMALU_WIDTH] ? negated : twos;

    // anything at or above bit 31 no longer fits the magnitude field.
    assign ovf    = |absVal[`SMALU_WIDTH:magW];
    assign magOut = ovf ? '1 : absVal[magW-1:0];

    // zero keeps the plus sign.
    assign sm = {twos[`SMALU_WIDTH] & (absVal != '0), magOut};

endmodule

// File: sim.f
+incdir+common
common/smAluPkg.sv
src/LookaheadAdder.sv
convert/SignMagToTwos.sv
convert/TwosToSignMag.sv
src/OperandStage.sv
src/ExecuteStage.sv
src/ResultStage.sv
src/SmAluTop.sv
bench/smAlu_asserts.sv
bench/SmAluTb.sv

// File: src/ExecuteStage.sv
// ExecuteStage adds the prepared operands and the carry term and registers the sum.
`timescale 1ns/1ps
`include "smAlu_params.svh"

module ExecuteStage (
    input  logic                clk,
    input  logic                rstN,
    input  logic                s1Valid,
    input  smAluPkg::twosWord_t s1A,
    input  smAluPkg::twosWord_t s1B,
    input  logic                s1Cin,
    output logic                s2Valid,
    output smAluPkg::twosWord_t s2Sum
);

    import smAluPkg::*;

    twosWord_t sumNext;

    // both operands stay within 2^31 in size, so 33 bits never wrap.
    LookaheadAdder #(
        .width(`SMALU_WIDTH + 1)
    ) mainAdder (
        .a   (s1A),
        .b   (s1B),
        .cin (s1Cin),
        .sum (sumNext),
        .cout()
    );

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            s2Valid <= 1'b0;
        end else begin
            s2Valid <= s1Valid;
        end
    end

    always_ff @(posedge clk) begin
        if (s1Valid) begin
            s2Sum <= sumNext; // held while the stage is empty.
        end
    end

endmodule

// File: src/LookaheadAdder.sv
// LookaheadAdder adds two words through 4-bit generate/propagate groups.
`timescale 1ns/1ps
`include "smAlu_params.svh"

module LookaheadAdder #(
    parameter int width = 33
) (
    input  logic [width-1:0] a,
    input  logic [width-1:0] b,
    input  logic             cin,
    output logic [width-1:0] sum,
    output logic             cout
);

    localparam int groupW = `SMALU_GROUP;
    localparam int groups = (width + groupW - 1) / groupW;
    localparam int padW   = groups * groupW; // the top group is zero padded.

    logic [padW-1:0]   aPad;
    logic [padW-1:0]   bPad;
    logic [padW-1:0]   gen;
    logic [padW-1:0]   prop;
    logic [padW-1:0]   carry;     // carry into each bit.
    logic [groups-1:0] grpGen;
    logic [groups-1:0] grpProp;
    logic [groups:0]   grpCarry;  // carry into each group.

    always_comb begin
        aPad = padW'(a);
        bPad = padW'(b);
        gen  = aPad & bPad;
        prop = aPad ^ bPad;

        // a group generates when its top bit generates, or propagates a lower generate.
        for (int k = 0; k < groups; k++) begin
            grpGen[k]  = 1'b0;
            grpProp[k] = 1'b1;
            for (int j = 0; j < groupW; j++) begin
                grpGen[k]  = gen[k*groupW+j] | (prop[k*groupW+j] & grpGen[k]);
                grpProp[k] = grpProp[k] & prop[k*groupW+j];
            end
        end

        grpCarry[0] = cin;
        for (int k = 0; k < groups; k++) begin
            grpCarry[k+1] = grpGen[k] | (grpProp[k] & grpCarry[k]);
        end

        // bit carries inside a group start from the group carry.
        for (int k = 0; k < groups; k++) begin
            carry[k*groupW] = grpCarry[k];
            for (int j = 1; j < groupW; j++) begin
                carry[k*groupW+j] = gen[k*groupW+j-1]
                                  | (prop[k*groupW+j-1] & carry[k*groupW+j-1]);
            end
        end

        sum = prop[width-1:0] ^ carry[width-1:0];
    end

    // with padding the carry out of the top real bit sits inside the last group.
    generate
        if (padW > width) begin : gPadCarry
            assign cout = carry[width];
        end else begin : gGroupCarry
            assign cout = grpCarry[groups];
        end
    endgenerate

endmodule

// File: src/OperandStage.sv
// OperandStage converts both operands to two's complement and folds in the carry term.
`timescale 1ns/1ps
`include "smAlu_params.svh"

module OperandStage (
    input  logic                clk,
    input  logic                rstN,
    input  logic                inValid,
    input  smAluPkg::aluOp_e    op,
    input  smAluPkg::smWord_t   op1,
    input  smAluPkg::smWord_t   op2,
    input  logic                carryIn,
    output logic                s1Valid,
    output smAluPkg::twosWord_t s1A,
    output smAluPkg::twosWord_t s1B,
    output logic                s1Cin
);

    import smAluPkg::*;

    smWord_t   op2Eff;
    twosWord_t aConv;
    twosWord_t bConv;
    twosWord_t bAdj;
    logic      isSub;
    logic      borrowFix;

    // ####################
    // operand preparation
    // ####################

    // subtraction becomes addition of op2 with its sign flipped.
    assign isSub  = (op == OP_SUB) || (op == OP_SUBB);
    assign op2Eff = {op2[`SMALU_WIDTH-1] ^ isSub, op2[`SMALU_WIDTH-2:0]};

    SignMagToTwos convA (
        .sm  (op1),
        .twos(aConv)
    );

    SignMagToTwos convB (
        .sm  (op2Eff),
        .twos(bConv)
    );

    // a set borrow-in takes one more off by adding all ones to B.
    assign borrowFix = (op == OP_SUBB) && carryIn;
    assign bAdj      = bConv + {(`SMALU_WIDTH + 1){borrowFix}};

    // ####################
    // stage registers
    // ####################

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            s1Valid <= 1'b0;
        end else begin
            s1Valid <= inValid;
        end
    end

    always_ff @(posedge clk) begin
        if (inValid) begin
            s1A   <= aConv;
            s1B   <= bAdj;
            s1Cin <= (op == OP_ADDC) && carryIn; // only add-with-carry uses the adder carry.
        end
    end

endmodule

// File: src/ResultStage.sv
// ResultStage converts the sum back to sign-magnitude and registers result and overflow.
`timescale 1ns/1ps

module ResultStage (
    input  logic                clk,
    input  logic                rstN,
    input  logic                s2Valid,
    input  smAluPkg::twosWord_t s2Sum,
    output logic                outValid,
    output smAluPkg::smWord_t   diff,
    output logic                ovf
);

    import smAluPkg::*;

    smWord_t smNext;
    logic    ovfNext;

    TwosToSignMag conv (
        .twos(s2Sum),
        .sm  (smNext),
        .ovf (ovfNext)
    );

    // ####################
    // output registers
    // ####################

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            outValid <= 1'b0;
        end else begin
            outValid <= s2Valid;
        end
    end

    // result and flag keep their last value between valid items.
    always_ff @(posedge clk) begin
        if (s2Valid) begin
            diff <= smNext;
            ovf  <= ovfNext;
        end
    end

endmodule

// File: src/SmAluTop.sv
// SmAluTop chains operand, execute and result stages into a three-cycle pipeline.
`timescale 1ns/1ps

module SmAluTop (
    input  logic              clk,
    input  logic              rstN,
    input  logic              inValid,
    input  smAluPkg::aluOp_e  op,
    input  smAluPkg::smWord_t op1,
    input  smAluPkg::smWord_t op2,
    input  logic              carryIn,
    output logic              outValid,
    output smAluPkg::smWord_t diff,
    output logic              ovf
);

    import smAluPkg::*;

    logic      s1Valid;
    twosWord_t s1A;
    twosWord_t s1B;
    logic      s1Cin;
    logic      s2Valid;
    twosWord_t s2Sum;

    OperandStage operandStage (
        .clk    (clk),
        .rstN   (rstN),
        .inValid(inValid),
        .op     (op),
        .op1    (op1),
        .op2    (op2),
        .carryIn(carryIn),
        .s1Valid(s1Valid),
        .s1A    (s1A),
        .s1B    (s1B),
        .s1Cin  (s1Cin)
    );

    ExecuteStage executeStage (
        .clk    (clk),
        .rstN   (rstN),
        .s1Valid(s1Valid),
        .s1A    (s1A),
        .s1B    (s1B),
        .s1Cin  (s1Cin),
        .s2Valid(s2Valid),
        .s2Sum  (s2Sum)
    );

    ResultStage resultStage (
        .clk     (clk),
        .rstN    (rstN),
        .s2Valid (s2Valid),
        .s2Sum   (s2Sum),
        .outValid(outValid),
        .diff    (diff),
        .ovf     (ovf)
    );

endmodule
